//--- logic/act_geom_pkg.sv
`default_nettype none

package act_geom_pkg;

    // ====================
    // geometry of the activation path
    // ====================

    // one global buffer word
    localparam int PORT_WIDTH  = 32;
    // one activation
    localparam int ELEM_WIDTH  = 8;
    // activations per block
    localparam int BLOCK_DEPTH = 8;

    typedef logic [PORT_WIDTH-1:0]               port_word_t;
    typedef logic [ELEM_WIDTH-1:0]               act_elem_t;
    // bit i set keeps activation i
    typedef logic [BLOCK_DEPTH-1:0]              flag_blk_t;
    // element 0 in the top byte
    typedef logic [BLOCK_DEPTH*ELEM_WIDTH-1:0]   act_blk_t;

endpackage

`default_nettype wire

//--- logic/gbf_pkg.sv
`default_nettype none

package gbf_pkg;

    // ====================
    // global buffer defaults
    // ====================

    // depth in port words
    localparam int ACT_DEPTH_DEF        = 16;
    localparam int FLAG_DEPTH_DEF       = 8;

    // request a refill once this many entries are free
    localparam int REFILL_THRESHOLD_DEF = 4;

endpackage

`default_nettype wire

//--- logic/gbf_ring_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module gbf_ring_buffer
    import gbf_pkg::*;
#(
    parameter type payload_t        = logic [31:0],
    parameter int  DEPTH            = ACT_DEPTH_DEF,
    parameter int  REFILL_THRESHOLD = REFILL_THRESHOLD_DEF
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clear,
    input  logic     wr_valid,
    input  payload_t wr_data,
    output logic     wr_ready,
    output logic     rd_valid,
    input  logic     rd_ready,
    output payload_t rd_data,
    output logic     refill_req
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // words held in the sram excluding the output register
    logic [CW-1:0] count;
    logic [CW-1:0] count_next;
    logic          wr_fire;
    logic          rd_en;

    assign wr_ready = (count != CW'(DEPTH));
    assign wr_fire  = wr_valid && wr_ready;
    // refill the output register when empty or being popped
    assign rd_en    = (count != '0) && (!rd_valid || rd_ready);

    always_comb begin
        count_next = count;
        if (wr_fire && !rd_en) begin
            count_next = count + 1'b1;
        end else if (!wr_fire && rd_en) begin
            count_next = count - 1'b1;
        end
    end

    // sram read data lands in the output register
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            rd_valid   <= 1'b0;
            refill_req <= 1'b1;
        end else if (clear) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            rd_valid   <= 1'b0;
            refill_req <= 1'b1;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            if (rd_en) begin
                rd_valid <= 1'b1;
            end else if (rd_ready) begin
                rd_valid <= 1'b0;
            end
            // free entries after this edge
            refill_req <= (DEPTH - int'(count_next)) >= REFILL_THRESHOLD;
        end
    end

endmodule

`default_nettype wire

//--- logic/word_unpacker.sv
`timescale 1ns/10ps
`default_nettype none

module word_unpacker #(
    parameter type word_t = logic [31:0],
    parameter type elem_t = logic [7:0]
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear,
    input  logic  in_valid,
    input  word_t in_data,
    output logic  in_ready,
    output logic  out_valid,
    input  logic  out_ready,
    output elem_t out_data
);

    localparam int WW        = $bits(word_t);
    localparam int EW        = $bits(elem_t);
    localparam int NUM_ELEMS = WW / EW;
    localparam int LW        = $clog2(NUM_ELEMS + 1);

    word_t         word_q;
    // elements still to hand out
    logic [LW-1:0] left_q;
    logic          in_fire;
    logic          out_fire;

    assign in_ready  = (left_q == '0);
    assign out_valid = (left_q != '0);
    assign in_fire   = in_valid && in_ready;
    assign out_fire  = out_valid && out_ready;

    // leftmost element always sits at the top
    assign out_data  = elem_t'(word_q[WW-1 -: EW]);

    always_ff @(posedge clk) begin
        if (in_fire) begin
            word_q <= in_data;
        end else if (out_fire) begin
            word_q <= word_t'(word_q << EW);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_q <= '0;
        end else if (clear) begin
            left_q <= '0;
        end else if (in_fire) begin
            left_q <= LW'(NUM_ELEMS);
        end else if (out_fire) begin
            left_q <= left_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/act_block_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module act_block_dispatch
    import act_geom_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      clear,
    input  logic      elem_valid,
    input  act_elem_t elem_data,
    output logic      elem_ready,
    input  logic      flag_valid,
    input  flag_blk_t flag_data,
    output logic      flag_ready,
    output logic      blk_valid,
    input  logic      blk_ready,
    output flag_blk_t blk_flags,
    output act_blk_t  blk_data
);

    localparam int CNT_W = $clog2(BLOCK_DEPTH + 1);

    act_blk_t         data_q;
    flag_blk_t        flag_q;
    logic [CNT_W-1:0] elem_cnt;
    logic             flag_full;
    logic             blk_full;
    logic             elem_fire;
    logic             flag_fire;
    logic             blk_fire;

    // slots stay full until the block leaves, so no new input meanwhile
    assign blk_full   = (elem_cnt == CNT_W'(BLOCK_DEPTH)) && flag_full;
    assign elem_ready = (elem_cnt != CNT_W'(BLOCK_DEPTH));
    assign flag_ready = !flag_full;
    assign elem_fire  = elem_valid && elem_ready;
    assign flag_fire  = flag_valid && flag_ready;
    assign blk_fire   = blk_valid && blk_ready;

    // ====================
    // slot capture
    // ====================
    // first arrival ends up in the top byte
    always_ff @(posedge clk) begin
        if (elem_fire) begin
            data_q <= {data_q[(BLOCK_DEPTH-1)*ELEM_WIDTH-1:0], elem_data};
        end
        if (flag_fire) begin
            flag_q <= flag_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            elem_cnt  <= '0;
            flag_full <= 1'b0;
            blk_valid <= 1'b0;
        end else if (clear || blk_fire) begin
            elem_cnt  <= '0;
            flag_full <= 1'b0;
            blk_valid <= 1'b0;
        end else begin
            if (elem_fire) begin
                elem_cnt <= elem_cnt + 1'b1;
            end
            if (flag_fire) begin
                flag_full <= 1'b1;
            end
            if (blk_full) begin
                blk_valid <= 1'b1;
            end
        end
    end

    // ====================
    // pruning mask
    // ====================
    assign blk_flags = flag_q;

    always_comb begin
        for (int i = 0; i < BLOCK_DEPTH; i++) begin
            blk_data[(BLOCK_DEPTH-1-i)*ELEM_WIDTH +: ELEM_WIDTH] =
                flag_q[i] ? data_q[(BLOCK_DEPTH-1-i)*ELEM_WIDTH +: ELEM_WIDTH] : '0;
        end
    end

endmodule

`default_nettype wire

//--- logic/act_fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module act_fetch_top
    import act_geom_pkg::*;
    import gbf_pkg::*;
#(
    parameter int ACT_DEPTH        = ACT_DEPTH_DEF,
    parameter int FLAG_DEPTH       = FLAG_DEPTH_DEF,
    parameter int REFILL_THRESHOLD = REFILL_THRESHOLD_DEF
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       layer_clear,
    input  logic       act_wr_valid,
    input  port_word_t act_wr_data,
    output logic       act_wr_ready,
    input  logic       flag_wr_valid,
    input  port_word_t flag_wr_data,
    output logic       flag_wr_ready,
    output logic       act_refill_req,
    output logic       flag_refill_req,
    output logic       blk_valid,
    input  logic       blk_ready,
    output flag_blk_t  blk_flags,
    output act_blk_t   blk_data
);

    // buffer to unpacker
    logic       act_pop_valid;
    logic       act_pop_ready;
    port_word_t act_pop_data;
    logic       flag_pop_valid;
    logic       flag_pop_ready;
    port_word_t flag_pop_data;

    // unpacker to dispatcher
    logic       elem_valid;
    logic       elem_ready;
    act_elem_t  elem_data;
    logic       flg_valid;
    logic       flg_ready;
    flag_blk_t  flg_data;

    // ====================
    // global buffers
    // ====================
    gbf_ring_buffer #(
        .payload_t        (port_word_t),
        .DEPTH            (ACT_DEPTH),
        .REFILL_THRESHOLD (REFILL_THRESHOLD)
    ) act_gbf_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (layer_clear),
        .wr_valid   (act_wr_valid),
        .wr_data    (act_wr_data),
        .wr_ready   (act_wr_ready),
        .rd_valid   (act_pop_valid),
        .rd_ready   (act_pop_ready),
        .rd_data    (act_pop_data),
        .refill_req (act_refill_req)
    );

    gbf_ring_buffer #(
        .payload_t        (port_word_t),
        .DEPTH            (FLAG_DEPTH),
        .REFILL_THRESHOLD (REFILL_THRESHOLD)
    ) flag_gbf_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (layer_clear),
        .wr_valid   (flag_wr_valid),
        .wr_data    (flag_wr_data),
        .wr_ready   (flag_wr_ready),
        .rd_valid   (flag_pop_valid),
        .rd_ready   (flag_pop_ready),
        .rd_data    (flag_pop_data),
        .refill_req (flag_refill_req)
    );

    // ====================
    // unpackers
    // ====================
    word_unpacker #(
        .word_t (port_word_t),
        .elem_t (act_elem_t)
    ) act_unpack_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (layer_clear),
        .in_valid  (act_pop_valid),
        .in_data   (act_pop_data),
        .in_ready  (act_pop_ready),
        .out_valid (elem_valid),
        .out_ready (elem_ready),
        .out_data  (elem_data)
    );

    // one flag byte per block
    word_unpacker #(
        .word_t (port_word_t),
        .elem_t (flag_blk_t)
    ) flag_unpack_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (layer_clear),
        .in_valid  (flag_pop_valid),
        .in_data   (flag_pop_data),
        .in_ready  (flag_pop_ready),
        .out_valid (flg_valid),
        .out_ready (flg_ready),
        .out_data  (flg_data)
    );

    act_block_dispatch act_dispatch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (layer_clear),
        .elem_valid (elem_valid),
        .elem_data  (elem_data),
        .elem_ready (elem_ready),
        .flag_valid (flg_valid),
        .flag_data  (flg_data),
        .flag_ready (flg_ready),
        .blk_valid  (blk_valid),
        .blk_ready  (blk_ready),
        .blk_flags  (blk_flags),
        .blk_data   (blk_data)
    );

endmodule

`default_nettype wire

//--- tb/act_fetch_checker.sv
`timescale 1ns/10ps
`default_nettype none

module act_fetch_checker
    import act_geom_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      layer_clear,
    input logic      blk_valid,
    input logic      blk_ready,
    input flag_blk_t blk_flags,
    input act_blk_t  blk_data
);

    int fail_cnt = 0;

    // pruned bytes must read as zero
    function automatic logic pruned_zero(input flag_blk_t f, input act_blk_t d);
        for (int i = 0; i < BLOCK_DEPTH; i++) begin
            if (!f[i] && (d[(BLOCK_DEPTH-1-i)*ELEM_WIDTH +: ELEM_WIDTH] != '0)) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // ====================
    // block handshake
    // ====================
    hold_until_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (blk_valid && !blk_ready && !layer_clear)
            |=> (blk_valid && $stable(blk_data) && $stable(blk_flags)))
        else begin
            fail_cnt++;
            $error("blk_valid or block data changed before blk_ready");
        end

    mask_applied: assert property (@(posedge clk) disable iff (!rst_n)
        blk_valid |-> pruned_zero(blk_flags, blk_data))
        else begin
            fail_cnt++;
            $error("nonzero byte under a clear flag bit");
        end

    clear_drops_valid: assert property (@(posedge clk) disable iff (!rst_n)
        layer_clear |=> !blk_valid)
        else begin
            fail_cnt++;
            $error("blk_valid high in the cycle after layer_clear");
        end

endmodule

bind act_fetch_top act_fetch_checker chk_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .layer_clear (layer_clear),
    .blk_valid   (blk_valid),
    .blk_ready   (blk_ready),
    .blk_flags   (blk_flags),
    .blk_data    (blk_data)
);

`default_nettype wire

//--- tb/act_fetch_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module act_fetch_monitor
    import act_geom_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      act_wr_ready,
    input logic      flag_wr_ready,
    input logic      act_refill_req,
    input logic      flag_refill_req,
    input logic      blk_valid,
    input logic      blk_ready,
    input flag_blk_t blk_flags,
    input act_blk_t  blk_data
);

    // blk_valid low, both write readies and both refill requests high
    localparam logic [4:0] IDLE_OUTPUTS = 5'b01111;

    string     exp_name[$];
    flag_blk_t exp_flags[$];
    act_blk_t  exp_data[$];

    int   blk_count = 0;
    int   pass_cnt  = 0;
    int   fail_cnt  = 0;
    int   stray_cnt = 0;
    int   pend_cnt  = 0;
    logic cur_bad   = 1'b0;

    // keep only test names and expected blocks
    initial begin
        int        fd;
        int        code;
        string     tok;
        string     name;
        string     rest;
        logic [31:0] word;
        flag_blk_t f;
        act_blk_t  d;
        name = "";
        fd = $fopen("tb/act_fetch_golden.txt", "r");
        if (fd == 0) begin
            $display("monitor could not open the golden file");
            stray_cnt++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    break;
                end
                case (tok)
                    "#": code = $fgets(rest, fd);
                    "T": code = $fscanf(fd, "%s", name);
                    "W", "F", "R": code = $fscanf(fd, "%h", word);
                    "B": begin
                        code = $fscanf(fd, "%h %h", f, d);
                        exp_name.push_back(name);
                        exp_flags.push_back(f);
                        exp_data.push_back(d);
                    end
                    default: ;
                endcase
            end
            $fclose(fd);
        end
        pend_cnt = exp_name.size();
    end

    // ====================
    // idle and stall checks
    // ====================
    function automatic logic [4:0] idle_state();
        return {blk_valid, act_wr_ready, flag_wr_ready, act_refill_req, flag_refill_req};
    endfunction

    task automatic check_idle(input string test);
        if (idle_state() !== IDLE_OUTPUTS) begin
            $display("ERROR test %s: expected idle outputs %b, actual %b", test,
                     IDLE_OUTPUTS, idle_state());
            cur_bad = 1'b1;
        end
    endtask

    task automatic check_reset();
        check_idle("reset_state");
        if (cur_bad) begin
            $display("test reset_state: failed");
            fail_cnt++;
        end else begin
            $display("test reset_state: ok");
            pass_cnt++;
        end
        cur_bad = 1'b0;
    endtask

    // full activation buffer withdraws its refill request
    task automatic check_stalled(input string test);
        if (act_refill_req !== 1'b0) begin
            $display("ERROR test %s: expected act_refill_req 0, actual %b", test,
                     act_refill_req);
            cur_bad = 1'b1;
        end
    endtask

    // ====================
    // compare each transferred block
    // ====================
    always @(posedge clk) begin
        string name;
        if (rst_n && blk_valid && blk_ready) begin
            blk_count++;
            if (exp_name.size() == 0) begin
                $display("block with flags %h arrived after all expected blocks", blk_flags);
                stray_cnt++;
            end else begin
                name = exp_name.pop_front();
                if (blk_flags !== exp_flags[0] || blk_data !== exp_data[0]) begin
                    $display("ERROR test %s: expected %h %h, actual %h %h", name,
                             exp_flags[0], exp_data[0], blk_flags, blk_data);
                    cur_bad = 1'b1;
                end
                void'(exp_flags.pop_front());
                void'(exp_data.pop_front());
                pend_cnt = exp_name.size();
                // last block of this test
                if (exp_name.size() == 0 || exp_name[0] != name) begin
                    if (cur_bad) begin
                        $display("test %s: failed", name);
                        fail_cnt++;
                    end else begin
                        $display("test %s: ok", name);
                        pass_cnt++;
                    end
                    cur_bad = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/act_fetch_tb.sv
`timescale 1ns/10ps
`default_nettype none

module act_fetch_tb
    import act_geom_pkg::*;
;

    localparam int WAIT_LIMIT = 2000;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       layer_clear;
    logic       act_wr_valid;
    port_word_t act_wr_data;
    logic       act_wr_ready;
    logic       flag_wr_valid;
    port_word_t flag_wr_data;
    logic       flag_wr_ready;
    logic       act_refill_req;
    logic       flag_refill_req;
    logic       blk_valid;
    logic       blk_ready = 1'b0;
    flag_blk_t  blk_flags;
    act_blk_t   blk_data;

    int          rdy_mode   = 0;
    logic [7:0]  lfsr_state = 8'd28;
    int          errs       = 0;
    int          exp_blocks = 0;
    string       cur_test   = "";

    always #50 clk = ~clk;

    act_fetch_top dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .layer_clear     (layer_clear),
        .act_wr_valid    (act_wr_valid),
        .act_wr_data     (act_wr_data),
        .act_wr_ready    (act_wr_ready),
        .flag_wr_valid   (flag_wr_valid),
        .flag_wr_data    (flag_wr_data),
        .flag_wr_ready   (flag_wr_ready),
        .act_refill_req  (act_refill_req),
        .flag_refill_req (flag_refill_req),
        .blk_valid       (blk_valid),
        .blk_ready       (blk_ready),
        .blk_flags       (blk_flags),
        .blk_data        (blk_data)
    );

    act_fetch_monitor mon_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .act_wr_ready    (act_wr_ready),
        .flag_wr_ready   (flag_wr_ready),
        .act_refill_req  (act_refill_req),
        .flag_refill_req (flag_refill_req),
        .blk_valid       (blk_valid),
        .blk_ready       (blk_ready),
        .blk_flags       (blk_flags),
        .blk_data        (blk_data)
    );

    // taps 8,6,5,4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // consumer side back-pressure
    always @(negedge clk) begin
        case (rdy_mode)
            0: blk_ready = 1'b0;
            1: blk_ready = 1'b1;
            default: begin
                lfsr_state = lfsr_next(lfsr_state);
                blk_ready  = lfsr_state[0];
            end
        endcase
    end

    // ====================
    // stimulus tasks
    // ====================
    task automatic push_word(input logic is_flag, input port_word_t w);
        int waited;
        waited = 0;
        if (is_flag) begin
            flag_wr_valid = 1'b1;
            flag_wr_data  = w;
        end else begin
            act_wr_valid = 1'b1;
            act_wr_data  = w;
        end
        while (!(is_flag ? flag_wr_ready : act_wr_ready) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT) begin
            $display("timeout waiting for write ready in test %s", cur_test);
            errs++;
        end else begin
            @(negedge clk);
        end
        act_wr_valid  = 1'b0;
        flag_wr_valid = 1'b0;
    endtask

    task automatic pulse_clear();
        layer_clear = 1'b1;
        @(negedge clk);
        layer_clear = 1'b0;
        mon_i.check_idle(cur_test);
    endtask

    task automatic wait_stall();
        int waited;
        waited = 0;
        while (act_wr_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT) begin
            $display("timeout waiting for act_wr_ready to fall in test %s", cur_test);
            errs++;
        end else begin
            mon_i.check_stalled(cur_test);
        end
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        if (cur_test == "") begin
            return;
        end
        while (mon_i.blk_count < exp_blocks && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT) begin
            $display("timeout waiting for the blocks of test %s", cur_test);
            errs++;
        end
        // drained buffers ask for a refill again
        waited = 0;
        while (!(act_refill_req && flag_refill_req) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT) begin
            $display("refill requests did not return high after test %s", cur_test);
            errs++;
        end
    endtask

    task automatic run_golden();
        int          fd;
        int          code;
        string       tok;
        string       rest;
        logic [31:0] word;
        logic [63:0] blk;
        fd = $fopen("tb/act_fetch_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden file");
            errs++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            case (tok)
                "#": code = $fgets(rest, fd);
                "T": begin
                    finish_test();
                    code = $fscanf(fd, "%s", cur_test);
                end
                "W": begin
                    code = $fscanf(fd, "%h", word);
                    push_word(1'b0, word);
                end
                "F": begin
                    code = $fscanf(fd, "%h", word);
                    push_word(1'b1, word);
                end
                "R": begin
                    code = $fscanf(fd, "%d", rdy_mode);
                    @(negedge clk);
                end
                "B": begin
                    code = $fscanf(fd, "%h %h", word, blk);
                    exp_blocks++;
                end
                "C": pulse_clear();
                "S": wait_stall();
                default: begin
                    $display("unknown line kind %s in the golden file", tok);
                    errs++;
                end
            endcase
        end
        $fclose(fd);
        finish_test();
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        rst_n         = 1'b0;
        layer_clear   = 1'b0;
        act_wr_valid  = 1'b0;
        act_wr_data   = '0;
        flag_wr_valid = 1'b0;
        flag_wr_data  = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        mon_i.check_reset();

        run_golden();
        repeat (2) @(negedge clk);

        if (mon_i.pend_cnt != 0) begin
            $display("%0d expected blocks never arrived", mon_i.pend_cnt);
            errs++;
        end
        errs = errs + mon_i.stray_cnt + dut_i.chk_i.fail_cnt;
        $display("tests passed: %0d, tests failed: %0d, other errors: %0d",
                 mon_i.pass_cnt, mon_i.fail_cnt, errs);
        if (mon_i.fail_cnt == 0 && errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/act_fetch_golden.txt
# kind and arguments: T name | W act word | F flag word | C clear | S stall check
# R mode (0 held low, 1 always ready, 2 random) | B flag byte, masked block
T basic_blocks
R 1
F ff0fa500
W 01020304
W 05060708
W 11121314
W 15161718
W 21222324
W 25262728
W 31323334
W 35363738
B ff 0102030405060708
B 0f 1112131400000000
B a5 2100230000260028
B 00 0000000000000000
T random_backpressure
R 2
F 813cf07e
W 41424344
W 45464748
W 51525354
W 55565758
W 61626364
W 65666768
W 71727374
W 75767778
B 81 4100000000000048
B 3c 0000535455560000
B f0 0000000065666768
B 7e 0072737475767700
T full_buffer
R 0
F ffffffff
F ffffffff
F ffffffff
W c0000001
W c0000002
W c0000003
W c0000004
W c0000005
W c0000006
W c0000007
W c0000008
W c0000009
W c000000a
W c000000b
W c000000c
W c000000d
W c000000e
W c000000f
W c0000010
W c0000011
W c0000012
W c0000013
W c0000014
S
R 1
B ff c0000001c0000002
B ff c0000003c0000004
B ff c0000005c0000006
B ff c0000007c0000008
B ff c0000009c000000a
B ff c000000bc000000c
B ff c000000dc000000e
B ff c000000fc0000010
B ff c0000011c0000012
B ff c0000013c0000014
T layer_clear
F f0f0f0f0
W 99999999
C
F c3000000
W d1d2d3d4
W d5d6d7d8
B c3 d1d200000000d7d8

//--- sources.f
logic/act_geom_pkg.sv
logic/gbf_pkg.sv
logic/gbf_ring_buffer.sv
logic/word_unpacker.sv
logic/act_block_dispatch.sv
logic/act_fetch_top.sv
tb/act_fetch_checker.sv
tb/act_fetch_monitor.sv
tb/act_fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the activation path regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module act_fetch_tb -o act_fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/act_fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
